// ==== Makefile ====
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/datapath.sv
hdl/controller.sv
hdl/hazard_unit.sv
hdl/rv_core.sv
tb/tb_rv_core.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire rv_isa_pkg::alu_op_t          i_op,
  input  wire logic [rv_pipe_pkg::XLEN-1:0] i_a,
  input  wire logic [rv_pipe_pkg::XLEN-1:0] i_b,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_y,
  output logic                              o_zero,
  output logic                              o_neg
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN-1:0] diff;
  logic            lt;

  assign diff = i_a - i_b;
  // sign of the exact difference, corrected for overflow
  assign lt = (i_a[XLEN-1] != i_b[XLEN-1]) ? i_a[XLEN-1] : diff[XLEN-1];

  always_comb begin
    unique case (i_op)
      ALU_ADD: o_y = i_a + i_b;
      ALU_SUB: o_y = diff;
      ALU_AND: o_y = i_a & i_b;
      ALU_OR:  o_y = i_a | i_b;
      ALU_SLT: o_y = {{(XLEN-1){1'b0}}, lt};
      default: o_y = '0;
    endcase
  end

  assign o_zero = (o_y == '0);
  assign o_neg  = lt;

endmodule

`default_nettype wire

// ==== hdl/controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module controller (
  input  wire logic                   clk,
  input  wire logic                   i_arst_n,
  input  wire logic [31:0]            i_inst_d,
  input  wire logic                   i_zero,
  input  wire logic                   i_neg,
  input  wire logic                   i_flush_e,
  output rv_isa_pkg::imm_sel_t        o_imm_sel,
  output logic                        o_is_jal,
  output rv_isa_pkg::alu_op_t         o_alu_op,
  output logic                        o_alu_src,
  output rv_pipe_pkg::pc_sel_t        o_pc_sel,
  output logic                        o_mem_we,
  output logic                        o_mem_re_e,
  output logic                        o_mem_re,
  output logic                        o_reg_we_m,
  output logic                        o_reg_we_w,
  output rv_pipe_pkg::res_sel_t       o_res_sel
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  ex_ctrl_t   dec, ex_q;
  mem_ctrl_t  mem_q;
  wb_ctrl_t   wb_q;

  assign opcode = i_inst_d[6:0];
  assign funct3 = i_inst_d[14:12];

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub);
    unique case (f3)
      F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
      F3_AND:  return ALU_AND;
      F3_OR:   return ALU_OR;
      F3_SLT:  return ALU_SLT;
      default: return ALU_ADD;
    endcase
  endfunction

  // ID decode
  always_comb begin
    dec       = '0;
    o_imm_sel = IMM_I;
    o_is_jal  = 1'b0;
    unique case (opcode)
      OP_R: begin
        dec.alu_op        = alu_decode(funct3, i_inst_d[31:25] == F7_SUB);
        dec.mem.wb.reg_we = 1'b1;
      end
      OP_I: begin
        dec.alu_op        = alu_decode(funct3, 1'b0);
        dec.alu_src       = 1'b1;
        dec.mem.wb.reg_we = 1'b1;
      end
      OP_LOAD: begin
        dec.alu_src        = 1'b1;
        dec.mem.mem_re     = 1'b1;
        dec.mem.wb.reg_we  = 1'b1;
        dec.mem.wb.res_sel = RES_MEM;
      end
      OP_STORE: begin
        o_imm_sel      = IMM_S;
        dec.alu_src    = 1'b1;
        dec.mem.mem_we = 1'b1;
      end
      OP_BRANCH: begin
        // compare by subtraction, zero flag decides
        o_imm_sel     = IMM_B;
        dec.alu_op    = ALU_SUB;
        dec.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        dec.br_ne     = (funct3 == F3_BNE);
      end
      OP_JAL: begin
        o_imm_sel         = IMM_J;
        o_is_jal          = 1'b1;
        dec.alu_src       = 1'b1;
        dec.mem.wb.reg_we = 1'b1;
      end
      default: ;
    endcase
  end

  pipe_reg #(.T(ex_ctrl_t)) u_ex_ctrl (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(i_flush_e),
    .i_d(dec), .o_q(ex_q)
  );

  pipe_reg #(.T(mem_ctrl_t)) u_mem_ctrl (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(1'b0),
    .i_d(ex_q.mem), .o_q(mem_q)
  );

  pipe_reg #(.T(wb_ctrl_t)) u_wb_ctrl (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(1'b0),
    .i_d(mem_q.wb), .o_q(wb_q)
  );

  // taken branch in EX overrides jal in ID
  always_comb begin
    if (ex_q.is_branch && (ex_q.br_ne ^ i_zero)) begin
      o_pc_sel = PC_BR;
    end else if (o_is_jal) begin
      o_pc_sel = PC_JAL;
    end else begin
      o_pc_sel = PC_SEQ;
    end
  end

  assign o_alu_op   = ex_q.alu_op;
  assign o_alu_src  = ex_q.alu_src;
  assign o_mem_re_e = ex_q.mem.mem_re;
  assign o_mem_we   = mem_q.mem_we;
  assign o_mem_re   = mem_q.mem_re;
  assign o_reg_we_m = mem_q.wb.reg_we;
  assign o_reg_we_w = wb_q.reg_we;
  assign o_res_sel  = wb_q.res_sel;

  a_mem_we_re_excl: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !(o_mem_we && o_mem_re)
  );

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
  input  wire logic                         clk,
  input  wire logic                         i_arst_n,
  input  wire logic [31:0]                  i_inst,
  input  wire logic [rv_pipe_pkg::XLEN-1:0] i_dmem_rdata,
  input  wire rv_isa_pkg::imm_sel_t         i_imm_sel,
  input  wire logic                         i_is_jal,
  input  wire rv_isa_pkg::alu_op_t          i_alu_op,
  input  wire logic                         i_alu_src,
  input  wire rv_pipe_pkg::pc_sel_t         i_pc_sel,
  input  wire logic                         i_reg_we,
  input  wire rv_pipe_pkg::res_sel_t        i_res_sel,
  input  wire rv_pipe_pkg::fwd_sel_t        i_fwd_a,
  input  wire rv_pipe_pkg::fwd_sel_t        i_fwd_b,
  input  wire logic                         i_stall,
  input  wire logic                         i_flush_d,
  input  wire logic                         i_flush_e,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_pc,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_dmem_addr,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_dmem_wdata,
  output logic      [31:0]                  o_inst_d,
  output logic                              o_zero,
  output logic                              o_neg,
  output logic      [4:0]                   o_rs1_d,
  output logic      [4:0]                   o_rs2_d,
  output logic      [4:0]                   o_rs1_e,
  output logic      [4:0]                   o_rs2_e,
  output logic      [4:0]                   o_rd_e,
  output logic      [4:0]                   o_rd_m,
  output logic      [4:0]                   o_rd_w
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  typedef struct packed {
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] wdata;
    logic [4:0]      rd;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] rdata;
    logic [4:0]      rd;
  } mem_wb_t;

  localparam if_id_t IF_ID_RST = '{inst: NOP_INST, pc: RESET_PC};

  logic [XLEN-1:0] pc_next, pc_plus4, jal_target, br_target;
  logic [XLEN-1:0] rd1_d, rd2_d, imm_d;
  logic [XLEN-1:0] src_a, fwd_b, src_b, alu_y_e, result_w;
  if_id_t          if_id_q;
  id_ex_t          id_ex_d, id_ex_q;
  ex_mem_t         ex_mem_q;
  mem_wb_t         mem_wb_q;

  // IF
  assign pc_plus4 = o_pc + 32'd4;

  always_comb begin
    unique case (i_pc_sel)
      PC_JAL:  pc_next = jal_target;
      PC_BR:   pc_next = br_target;
      default: pc_next = pc_plus4;
    endcase
  end

  pipe_reg #(.T(logic [XLEN-1:0]), .RESET_VAL(RESET_PC)) u_pc_reg (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(!i_stall), .i_clr(1'b0),
    .i_d(pc_next), .o_q(o_pc)
  );

  pipe_reg #(.T(if_id_t), .RESET_VAL(IF_ID_RST)) u_if_id (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(!i_stall), .i_clr(i_flush_d),
    .i_d(if_id_t'{inst: i_inst, pc: o_pc}), .o_q(if_id_q)
  );

  // ID
  assign o_inst_d = if_id_q.inst;
  assign o_rs1_d  = o_inst_d[19:15];
  assign o_rs2_d  = o_inst_d[24:20];

  reg_file u_reg_file (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_we(i_reg_we), .i_waddr(o_rd_w), .i_wdata(result_w),
    .i_raddr1(o_rs1_d), .i_raddr2(o_rs2_d),
    .o_rdata1(rd1_d), .o_rdata2(rd2_d)
  );

  always_comb begin
    unique case (i_imm_sel)
      IMM_S:   imm_d = {{20{o_inst_d[31]}}, o_inst_d[31:25], o_inst_d[11:7]};
      IMM_B:   imm_d = {{20{o_inst_d[31]}}, o_inst_d[7], o_inst_d[30:25],
                        o_inst_d[11:8], 1'b0};
      IMM_J:   imm_d = {{12{o_inst_d[31]}}, o_inst_d[19:12], o_inst_d[20],
                        o_inst_d[30:21], 1'b0};
      default: imm_d = {{20{o_inst_d[31]}}, o_inst_d[31:20]};
    endcase
  end

  assign jal_target = if_id_q.pc + imm_d;

  // jal turns into pc + 4 through the alu, rs1 forced to x0 so nothing forwards
  always_comb begin
    id_ex_d.rd1 = i_is_jal ? if_id_q.pc : rd1_d;
    id_ex_d.rd2 = rd2_d;
    id_ex_d.imm = i_is_jal ? 32'd4 : imm_d;
    id_ex_d.pc  = if_id_q.pc;
    id_ex_d.rs1 = i_is_jal ? 5'd0 : o_rs1_d;
    id_ex_d.rs2 = o_rs2_d;
    id_ex_d.rd  = o_inst_d[11:7];
  end

  pipe_reg #(.T(id_ex_t)) u_id_ex (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(i_flush_e),
    .i_d(id_ex_d), .o_q(id_ex_q)
  );

  // EX
  assign o_rs1_e = id_ex_q.rs1;
  assign o_rs2_e = id_ex_q.rs2;
  assign o_rd_e  = id_ex_q.rd;

  always_comb begin
    unique case (i_fwd_a)
      FWD_MEM: src_a = ex_mem_q.alu_y;
      FWD_WB:  src_a = result_w;
      default: src_a = id_ex_q.rd1;
    endcase
    unique case (i_fwd_b)
      FWD_MEM: fwd_b = ex_mem_q.alu_y;
      FWD_WB:  fwd_b = result_w;
      default: fwd_b = id_ex_q.rd2;
    endcase
  end

  assign src_b     = i_alu_src ? id_ex_q.imm : fwd_b;
  assign br_target = id_ex_q.pc + id_ex_q.imm;

  alu u_alu (
    .i_op(i_alu_op), .i_a(src_a), .i_b(src_b),
    .o_y(alu_y_e), .o_zero(o_zero), .o_neg(o_neg)
  );

  pipe_reg #(.T(ex_mem_t)) u_ex_mem (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(1'b0),
    .i_d(ex_mem_t'{alu_y: alu_y_e, wdata: fwd_b, rd: id_ex_q.rd}), .o_q(ex_mem_q)
  );

  // MEM
  assign o_dmem_addr  = ex_mem_q.alu_y;
  assign o_dmem_wdata = ex_mem_q.wdata;
  assign o_rd_m       = ex_mem_q.rd;

  pipe_reg #(.T(mem_wb_t)) u_mem_wb (
    .clk(clk), .i_arst_n(i_arst_n), .i_en(1'b1), .i_clr(1'b0),
    .i_d(mem_wb_t'{alu_y: ex_mem_q.alu_y, rdata: i_dmem_rdata, rd: ex_mem_q.rd}),
    .o_q(mem_wb_q)
  );

  // WB
  assign o_rd_w   = mem_wb_q.rd;
  assign result_w = (i_res_sel == RES_MEM) ? mem_wb_q.rdata : mem_wb_q.alu_y;

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  wire logic [4:0]           i_rs1_d,
  input  wire logic [4:0]           i_rs2_d,
  input  wire logic [4:0]           i_rs1_e,
  input  wire logic [4:0]           i_rs2_e,
  input  wire logic [4:0]           i_rd_e,
  input  wire logic [4:0]           i_rd_m,
  input  wire logic [4:0]           i_rd_w,
  input  wire logic                 i_reg_we_m,
  input  wire logic                 i_reg_we_w,
  input  wire logic                 i_mem_re_e,
  input  wire rv_pipe_pkg::pc_sel_t i_pc_sel,
  input  wire logic                 i_is_jal,
  output rv_pipe_pkg::fwd_sel_t     o_fwd_a,
  output rv_pipe_pkg::fwd_sel_t     o_fwd_b,
  output logic                      o_stall,
  output logic                      o_flush_d,
  output logic                      o_flush_e
);

  import rv_pipe_pkg::*;

  logic br_taken;
  logic lw_stall;

  // the younger result in MEM wins over WB
  function automatic fwd_sel_t pick_fwd(input logic [4:0] rs);
    if (i_reg_we_m && i_rd_m != 5'd0 && i_rd_m == rs) begin
      return FWD_MEM;
    end else if (i_reg_we_w && i_rd_w != 5'd0 && i_rd_w == rs) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  always_comb begin
    o_fwd_a = pick_fwd(i_rs1_e);
    o_fwd_b = pick_fwd(i_rs2_e);
  end

  assign br_taken = (i_pc_sel == PC_BR);
  assign lw_stall = i_mem_re_e && (i_rd_e != 5'd0) &&
                    ((i_rd_e == i_rs1_d) || (i_rd_e == i_rs2_d));

  // wrong-path ID instruction after a taken branch needs no stall
  assign o_stall   = lw_stall && !br_taken;
  // a stalled jal keeps its slot until the stall clears
  assign o_flush_d = br_taken || (i_is_jal && !o_stall);
  assign o_flush_e = br_taken || o_stall;

endmodule

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type T         = logic,
  parameter T    RESET_VAL = T'('0)
) (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_en,
  input  wire logic i_clr,
  input  wire T     i_d,
  output T          o_q
);

  // clear wins over enable so a flush also beats a stall
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_q <= RESET_VAL;
    end else if (i_clr) begin
      o_q <= RESET_VAL;
    end else if (i_en) begin
      o_q <= i_d;
    end
  end

  a_clr_loads_reset_val: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_clr |=> (o_q == RESET_VAL)
  );

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  wire logic                         clk,
  input  wire logic                         i_arst_n,
  input  wire logic                         i_we,
  input  wire logic [4:0]                   i_waddr,
  input  wire logic [rv_pipe_pkg::XLEN-1:0] i_wdata,
  input  wire logic [4:0]                   i_raddr1,
  input  wire logic [4:0]                   i_raddr2,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_rdata1,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_rdata2
);

  import rv_pipe_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (i_we && i_waddr != 5'd0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // write data bypasses to the same-cycle read in ID
  function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (i_we && addr == i_waddr) begin
      return i_wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    o_rdata1 = read_port(i_raddr1);
    o_rdata2 = read_port(i_raddr2);
  end

  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_raddr1 == 5'd0 |-> o_rdata1 == '0) and (i_raddr2 == 5'd0 |-> o_rdata2 == '0)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  wire logic                         clk,
  input  wire logic                         i_arst_n,
  input  wire logic [31:0]                  i_imem_rdata,
  input  wire logic [rv_pipe_pkg::XLEN-1:0] i_dmem_rdata,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_imem_addr,
  output logic                              o_dmem_we,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_dmem_addr,
  output logic      [rv_pipe_pkg::XLEN-1:0] o_dmem_wdata
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [31:0] inst_d;
  logic        zero, neg;
  imm_sel_t    imm_sel;
  alu_op_t     alu_op;
  pc_sel_t     pc_sel;
  res_sel_t    res_sel;
  fwd_sel_t    fwd_a, fwd_b;
  logic        is_jal, alu_src, mem_re_e, reg_we_m, reg_we_w;
  logic        stall, flush_d, flush_e;
  logic [4:0]  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, rd_m, rd_w;

  datapath u_datapath (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_inst(i_imem_rdata), .i_dmem_rdata(i_dmem_rdata),
    .i_imm_sel(imm_sel), .i_is_jal(is_jal), .i_alu_op(alu_op), .i_alu_src(alu_src),
    .i_pc_sel(pc_sel), .i_reg_we(reg_we_w), .i_res_sel(res_sel),
    .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
    .i_stall(stall), .i_flush_d(flush_d), .i_flush_e(flush_e),
    .o_pc(o_imem_addr), .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
    .o_inst_d(inst_d), .o_zero(zero), .o_neg(neg),
    .o_rs1_d(rs1_d), .o_rs2_d(rs2_d), .o_rs1_e(rs1_e), .o_rs2_e(rs2_e),
    .o_rd_e(rd_e), .o_rd_m(rd_m), .o_rd_w(rd_w)
  );

  // MEM read strobe stays internal since the data memory reads every cycle
  controller u_controller (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_inst_d(inst_d), .i_zero(zero), .i_neg(neg), .i_flush_e(flush_e),
    .o_imm_sel(imm_sel), .o_is_jal(is_jal), .o_alu_op(alu_op), .o_alu_src(alu_src),
    .o_pc_sel(pc_sel), .o_mem_we(o_dmem_we), .o_mem_re_e(mem_re_e), .o_mem_re(),
    .o_reg_we_m(reg_we_m), .o_reg_we_w(reg_we_w), .o_res_sel(res_sel)
  );

  hazard_unit u_hazard_unit (
    .i_rs1_d(rs1_d), .i_rs2_d(rs2_d), .i_rs1_e(rs1_e), .i_rs2_e(rs2_e),
    .i_rd_e(rd_e), .i_rd_m(rd_m), .i_rd_w(rd_w),
    .i_reg_we_m(reg_we_m), .i_reg_we_w(reg_we_w), .i_mem_re_e(mem_re_e),
    .i_pc_sel(pc_sel), .i_is_jal(is_jal),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
    .o_stall(stall), .o_flush_d(flush_d), .o_flush_e(flush_e)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // alu operations of the supported subset
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  // major opcodes
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // immediate formats
  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J
  } imm_sel_t;

endpackage

`default_nettype wire

// ==== hdl/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  // addi x0, x0, 0
  localparam logic [31:0]     NOP_INST = 32'h0000_0013;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_JAL,
    PC_BR
  } pc_sel_t;

  typedef enum logic {
    RES_ALU,
    RES_MEM
  } res_sel_t;

  typedef struct packed {
    logic     reg_we;
    res_sel_t res_sel;
  } wb_ctrl_t;

  typedef struct packed {
    logic     mem_we;
    logic     mem_re;
    wb_ctrl_t wb;
  } mem_ctrl_t;

  // alu_src set selects the immediate as second operand
  typedef struct packed {
    rv_isa_pkg::alu_op_t alu_op;
    logic                alu_src;
    logic                is_branch;
    logic                br_ne;
    mem_ctrl_t           mem;
  } ex_ctrl_t;

endpackage

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int          IMEM_WORDS     = 64;
  localparam int          DMEM_WORDS     = 64;
  localparam int          NUM_TESTS      = 6;
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * 200;
  localparam logic [31:0] SEED           = 32'h78da_6bfe;
  // last data word, written once a program has finished
  localparam logic [11:0] MARKER_OFS     = 12'd252;

  logic            clk;
  logic            i_arst_n = 1'b0;
  logic [31:0]     i_imem_rdata;
  logic [XLEN-1:0] i_dmem_rdata;
  logic [XLEN-1:0] o_imem_addr;
  logic            o_dmem_we;
  logic [XLEN-1:0] o_dmem_addr;
  logic [XLEN-1:0] o_dmem_wdata;

  logic [31:0]     imem [0:IMEM_WORDS-1];
  logic [XLEN-1:0] dmem [0:DMEM_WORDS-1];
  logic [31:0]     prog[$];
  logic [XLEN-1:0] st_addr[$];
  logic [XLEN-1:0] st_data[$];
  logic [XLEN-1:0] exp_addr[$];
  logic [XLEN-1:0] exp_data[$];
  logic            prog_done;
  int unsigned     cycles = 0;
  int              tests = 0;
  int              checks = 0;
  int              errors = 0;
  int              checks_start;
  int              errors_start;
  string           cur_test;

  rv_core DUT (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_imem_rdata(i_imem_rdata), .i_dmem_rdata(i_dmem_rdata),
    .o_imem_addr(o_imem_addr), .o_dmem_we(o_dmem_we),
    .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // both memories answer in the same cycle
  assign i_imem_rdata = imem[o_imem_addr[7:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[7:2]];

  function automatic logic [XLEN-1:0] fill_word(input int idx);
    return 32'h5a5a_0000 ^ XLEN'(idx * 4);
  endfunction

  // data memory, store log and end-of-program marker
  always @(posedge clk) begin
    if (!i_arst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
      st_addr.delete();
      st_data.delete();
      prog_done <= 1'b0;
    end else if (o_dmem_we) begin
      dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;
      if (o_dmem_addr == XLEN'(MARKER_OFS)) begin
        prog_done <= 1'b1;
      end else begin
        st_addr.push_back(o_dmem_addr);
        st_data.push_back(o_dmem_wdata);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // instruction encoders
  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, F3_ADD, rd, OP_I};
  endfunction

  // funct3 010 selects a word access
  function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, OP_LOAD};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] rr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3,
                                          input logic [6:0] f7);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] ofs);
    return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] ofs);
    return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [XLEN-1:0] sext12(input logic [11:0] imm);
    return {{(XLEN-12){imm[11]}}, imm};
  endfunction

  function automatic void emit(input logic [31:0] word);
    prog.push_back(word);
  endfunction

  function automatic void expect_store(input logic [XLEN-1:0] addr,
                                       input logic [XLEN-1:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  task automatic check_word(input string what, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("CHECK FAILED [%s] %s: expected 0x%08h, actual 0x%08h",
               cur_test, what, exp_val, act_val);
    end
  endtask

  task automatic check_ctrl(input string what, input logic exp_val, input logic act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("CHECK FAILED [%s] %s: expected %b, actual %b",
               cur_test, what, exp_val, act_val);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    tests++;
    checks_start = checks;
    errors_start = errors;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic report_test();
    $display("%-16s finished: %0d checks, %0d errors",
             cur_test, checks - checks_start, errors - errors_start);
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP_INST;
    end
  endtask

  // 16 cycles of reset, program loaded while the core is held
  task automatic apply_reset(input bit check_state);
    @(posedge clk);
    i_arst_n <= 1'b0;
    @(posedge clk);
    load_program();
    repeat (14) @(posedge clk);
    if (check_state) begin
      @(negedge clk);
      check_word("pc during reset", RESET_PC, o_imem_addr);
      check_ctrl("dmem we during reset", 1'b0, o_dmem_we);
    end
    @(posedge clk);
    i_arst_n <= 1'b1;
    if (check_state) begin
      @(negedge clk);
      check_word("pc after reset", RESET_PC, o_imem_addr);
      check_ctrl("dmem we after reset", 1'b0, o_dmem_we);
    end
  endtask

  task automatic compare_stores();
    check_word("store count", XLEN'(exp_addr.size()), XLEN'(st_addr.size()));
    for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
      check_word($sformatf("store %0d address", i), exp_addr[i], st_addr[i]);
      check_word($sformatf("store %0d data", i), exp_data[i], st_data[i]);
    end
  endtask

  task automatic run_program(input bit check_reset);
    emit(sw_word(5'd0, 5'd0, MARKER_OFS));
    // park the core on a jump to itself
    emit(jal_word(5'd0, 21'd0));
    apply_reset(check_reset);
    while (!prog_done) begin
      @(posedge clk);
    end
    compare_stores();
  endtask

  task automatic reset_behavior();
    begin_test("reset");
    run_program(1'b1);
    report_test();
  endtask

  task automatic alu_forwarding();
    logic [11:0]     imm_a;
    logic [11:0]     imm_b;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] conj;
    logic [XLEN-1:0] disj;
    begin_test("alu_forwarding");
    imm_a = 12'($urandom());
    imm_b = 12'($urandom());
    a     = sext12(imm_a);
    b     = sext12(imm_b);
    sum   = a + b;
    diff  = a - b;
    conj  = sum & diff;
    disj  = diff | conj;
    emit(addi_word(5'd1, 5'd0, imm_a));
    emit(addi_word(5'd2, 5'd0, imm_b));
    emit(rr_word(5'd3, 5'd1, 5'd2, F3_ADD, 7'd0));
    // store data comes straight from MEM
    emit(sw_word(5'd3, 5'd0, 12'd0));
    emit(rr_word(5'd4, 5'd1, 5'd2, F3_ADD, F7_SUB));
    emit(rr_word(5'd5, 5'd3, 5'd4, F3_AND, 7'd0));
    emit(rr_word(5'd6, 5'd4, 5'd5, F3_OR, 7'd0));
    emit(rr_word(5'd7, 5'd1, 5'd2, F3_SLT, 7'd0));
    emit(rr_word(5'd8, 5'd2, 5'd1, F3_SLT, 7'd0));
    for (int r = 4; r <= 8; r++) begin
      emit(sw_word(5'(r), 5'd0, 12'((r - 3) * 4)));
    end
    expect_store(32'd0, sum);
    expect_store(32'd4, diff);
    expect_store(32'd8, conj);
    expect_store(32'd12, disj);
    expect_store(32'd16, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    expect_store(32'd20, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    run_program(1'b0);
    report_test();
  endtask

  task automatic load_use();
    logic [11:0] imm_v;
    logic [11:0] imm_k;
    begin_test("load_use");
    imm_v = 12'($urandom());
    imm_k = 12'($urandom());
    emit(addi_word(5'd1, 5'd0, imm_v));
    emit(sw_word(5'd1, 5'd0, 12'd32));
    emit(lw_word(5'd2, 5'd0, 12'd32));
    emit(addi_word(5'd3, 5'd2, imm_k));
    emit(sw_word(5'd3, 5'd0, 12'd36));
    expect_store(32'd32, sext12(imm_v));
    expect_store(32'd36, sext12(imm_v) + sext12(imm_k));
    run_program(1'b0);
    report_test();
  endtask

  task automatic branches();
    begin_test("branches");
    emit(addi_word(5'd1, 5'd0, 12'd5));
    emit(addi_word(5'd2, 5'd0, 12'd5));
    emit(addi_word(5'd3, 5'd0, 12'd7));
    // beq taken, 12 -> 24
    emit(branch_word(F3_BEQ, 5'd1, 5'd2, 13'd12));
    emit(sw_word(5'd1, 5'd0, 12'd64));
    emit(sw_word(5'd1, 5'd0, 12'd68));
    emit(sw_word(5'd2, 5'd0, 12'd72));
    emit(branch_word(F3_BEQ, 5'd1, 5'd3, 13'd8));
    emit(sw_word(5'd3, 5'd0, 12'd76));
    // bne taken, 36 -> 48
    emit(branch_word(F3_BNE, 5'd1, 5'd3, 13'd12));
    emit(sw_word(5'd3, 5'd0, 12'd80));
    emit(sw_word(5'd3, 5'd0, 12'd84));
    emit(sw_word(5'd1, 5'd0, 12'd88));
    emit(branch_word(F3_BNE, 5'd1, 5'd2, 13'd8));
    emit(sw_word(5'd2, 5'd0, 12'd92));
    expect_store(32'd72, 32'd5);
    expect_store(32'd76, 32'd7);
    expect_store(32'd88, 32'd5);
    expect_store(32'd92, 32'd5);
    run_program(1'b0);
    check_word("word 64 untouched", fill_word(16), dmem[16]);
    check_word("word 68 untouched", fill_word(17), dmem[17]);
    check_word("word 80 untouched", fill_word(20), dmem[20]);
    check_word("word 84 untouched", fill_word(21), dmem[21]);
    report_test();
  endtask

  task automatic jal_link();
    logic [XLEN-1:0] jal_pc;
    begin_test("jal_link");
    jal_pc = 32'd4;
    emit(addi_word(5'd1, 5'd0, 12'd1));
    emit(jal_word(5'd5, 21'd12));
    emit(sw_word(5'd1, 5'd0, 12'd96));
    emit(sw_word(5'd1, 5'd0, 12'd100));
    emit(sw_word(5'd5, 5'd0, 12'd104));
    expect_store(32'd104, jal_pc + 32'd4);
    run_program(1'b0);
    check_word("word 96 untouched", fill_word(24), dmem[24]);
    report_test();
  endtask

  task automatic x0_write();
    begin_test("x0_write");
    emit(addi_word(5'd1, 5'd0, 12'd77));
    emit(addi_word(5'd0, 5'd1, 12'd5));
    emit(sw_word(5'd0, 5'd0, 12'd112));
    emit(rr_word(5'd0, 5'd1, 5'd1, F3_ADD, 7'd0));
    emit(sw_word(5'd0, 5'd0, 12'd116));
    expect_store(32'd112, 32'd0);
    expect_store(32'd116, 32'd0);
    run_program(1'b0);
    report_test();
  endtask

  initial begin
    void'($urandom(SEED));
    load_program();
    reset_behavior();
    alu_forwarding();
    load_use();
    branches();
    jal_link();
    x0_write();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
